// File: src.f
rtl/mmu_pkg.sv
rtl/mmu_tlb.sv
rtl/mmu_ptw.sv
rtl/mmu_mem_port.sv
rtl/riscv_mmu.sv
rtl/mmu_top.sv
tb/tb_clkgen.sv
tb/mmu_checker.sv
tb/mmu_sva.sv
tb/tb_mmu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the MMU testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_mmu -o tb_mmu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_mmu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF '*** FAILED ***' "$LOG"; then
  exit 1
fi
exit 0

// File: tb/tb_mmu.sv
/* Testbench for mmu_top with a 4096-word memory indexed by physical address bits 13:2
   All 4 KiB frames alias onto four words blocks, so page offsets are kept apart */

`timescale 1ns/1ps
`default_nettype none

module tb_mmu;

  import mmu_pkg::*;

  localparam int N_ACCESS      = 25;
  localparam int ACCESS_CYCLES = 40;
  localparam int SETUP_CYCLES  = 200;
  localparam int MEM_WORDS     = 4096;

  logic     clk;
  logic     rst;
  satp_t    satp        = '0;
  logic     tlb_flush   = 1'b0;
  logic     cpu_cyc     = 1'b0;
  logic     cpu_stb     = 1'b0;
  cpu_req_t cpu_req     = '0;
  logic     cpu_ack;
  logic     cpu_err;
  data_t    cpu_dat;
  data_t    mem_dat     = '0;
  logic     mem_ack     = 1'b0;
  logic     mem_cyc;
  logic     mem_stb;
  mem_req_t mem_req;

  // Expectations for the checker
  paddr_t   exp_adr     = '0;
  logic     exp_we      = 1'b0;
  logic     exp_err     = 1'b0;
  logic     exp_rd      = 1'b0;
  int       exp_cycles  = 0;
  data_t    exp_dat     = '0;
  logic     test_end    = 1'b0;
  int       test_id     = 0;
  int       checks;
  int       errors;
  int       timeouts    = 0;

  // Memory model with a backdoor write port
  data_t       mem [MEM_WORDS];
  logic        bd_we    = 1'b0;
  logic [11:0] bd_idx   = '0;
  data_t       bd_dat   = '0;
  integer      seed     = 32'h4e0fa024;
  int          delay;
  int          left;
  logic        pend;

  // TLB model, four entries round robin
  tlb_entry_t  tlb_m [TLB_ENTRIES];
  logic [TLB_ENTRIES-1:0] tlb_v   = '0;
  logic [1:0]  tlb_ptr = '0;

  tb_clkgen #(.RST_CYCLES(8)) clkgen0 (.clk_o(clk), .rst_o(rst));

  mmu_top dut0 (
    .clk_i (clk), .rst_i (rst), .satp_i (satp), .tlb_flush_i (tlb_flush),
    .cpu_cyc_i (cpu_cyc), .cpu_stb_i (cpu_stb), .cpu_req_i (cpu_req),
    .cpu_ack_o (cpu_ack), .cpu_err_o (cpu_err), .cpu_dat_o (cpu_dat),
    .mem_dat_i (mem_dat), .mem_ack_i (mem_ack), .mem_cyc_o (mem_cyc),
    .mem_stb_o (mem_stb), .mem_req_o (mem_req)
  );

  mmu_checker checker0 (
    .clk_i (clk), .rst_i (rst), .cpu_ack_i (cpu_ack), .cpu_err_i (cpu_err),
    .cpu_dat_i (cpu_dat), .mem_cyc_i (mem_cyc), .mem_stb_i (mem_stb),
    .mem_ack_i (mem_ack), .mem_req_i (mem_req), .exp_adr_i (exp_adr),
    .exp_we_i (exp_we), .exp_err_i (exp_err), .exp_rd_i (exp_rd),
    .exp_cycles_i (exp_cycles), .exp_dat_i (exp_dat), .test_end_i (test_end),
    .test_id_i (test_id), .checks_o (checks), .errors_o (errors)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone memory model
  ////////////////////////////////////////////////////////////////////////////

  task automatic serve_bus();
    logic [11:0] idx;
    idx = mem_req.adr[13:2];
    mem_ack <= 1'b1;
    mem_dat <= mem[idx];
    if (mem_req.we)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (mem_req.sel[b])
          mem[idx][8*b +: 8] <= mem_req.wdata[8*b +: 8];
      end
    end
  endtask

  // Ack after 1 to 3 cycles
  always @(posedge clk)
  begin
    mem_ack <= 1'b0;
    if (rst)
    begin
      pend <= 1'b0;
      left <= 0;
      for (int i = 0; i < MEM_WORDS; i++)
        mem[i] <= '0;
    end
    else
    begin
      if (bd_we)
        mem[bd_idx] <= bd_dat;
      if (mem_cyc && mem_stb && !mem_ack)
      begin
        if (!pend)
        begin
          delay = int'($unsigned($random(seed)) % 3);
          if (delay == 0)
            serve_bus();
          else
          begin
            pend <= 1'b1;
            left <= delay - 1;
          end
        end
        else if (left == 0)
        begin
          serve_bus();
          pend <= 1'b0;
        end
        else
          left <= left - 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference translation
  ////////////////////////////////////////////////////////////////////////////

  // Software Sv32 walk, updates the TLB model like a fill would
  function automatic void ref_translate(input vaddr_t va, input logic we,
                                        output paddr_t pa, output logic fault,
                                        output int cycles);
    vpn_t       vpn;
    pte_t       pte;
    paddr_t     tadr;
    ppn_t       ppn;
    tlb_entry_t e;
    logic       found;
    logic       leaf;
    vpn    = va[31:12];
    pa     = '0;
    fault  = 1'b0;
    cycles = 0;
    found  = 1'b0;
    e      = '0;
    if (satp.mode != SATP_MODE_SV32)
    begin
      pa     = {2'b00, va};
      cycles = 1;
      return;
    end
    for (int i = 0; i < TLB_ENTRIES; i++)
    begin
      if (tlb_v[i] && tlb_m[i].vpn[19:10] == vpn[19:10] &&
          (tlb_m[i].sp || tlb_m[i].vpn[9:0] == vpn[9:0]))
      begin
        found = 1'b1;
        e     = tlb_m[i];
      end
    end
    if (!found)
    begin
      tadr   = {satp.ppn, vpn[19:10], 2'b00};
      pte    = mem[tadr[13:2]];
      cycles = 1;
      ppn    = pte[31:10];
      leaf   = pte[1] || pte[3];
      // Invalid, reserved W only, misaligned superpage
      if (!pte[0] || (pte[2] && !pte[1]) || (leaf && ppn[9:0] != 10'd0))
      begin
        fault = 1'b1;
        return;
      end
      e = '{vpn: vpn, ppn: ppn, sp: 1'b1, r: pte[1], w: pte[2]};
      if (!leaf)
      begin
        tadr   = {ppn, vpn[9:0], 2'b00};
        pte    = mem[tadr[13:2]];
        cycles = 2;
        if (!pte[0] || (pte[2] && !pte[1]) || !(pte[1] || pte[3]))
        begin
          fault = 1'b1;
          return;
        end
        e = '{vpn: vpn, ppn: pte[31:10], sp: 1'b0, r: pte[1], w: pte[2]};
      end
      tlb_m[tlb_ptr] = e;
      tlb_v[tlb_ptr] = 1'b1;
      tlb_ptr        = tlb_ptr + 2'd1;
    end
    if (we ? !e.w : !e.r)
    begin
      fault = 1'b1;
      return;
    end
    pa     = e.sp ? {e.ppn[21:10], vpn[9:0], va[11:0]} : {e.ppn, va[11:0]};
    cycles = cycles + 1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic pte_t make_pte(input ppn_t ppn, input logic [3:0] flags);
    return {ppn, 6'b0, flags};
  endfunction

  // Test pages k at vpn1 = 1, offset k*0x20
  function automatic vaddr_t page_va(input int k);
    return 32'h0040_0000 + 32'(k) * 32'h1000 + 32'(k) * 32'h20;
  endfunction

  task automatic poke(input paddr_t pa, input data_t val);
    @(posedge clk);
    bd_we  <= 1'b1;
    bd_idx <= pa[13:2];
    bd_dat <= val;
    @(posedge clk);
    bd_we  <= 1'b0;
  endtask

  task automatic access(input vaddr_t va, input logic we, input data_t wdata,
                        input logic check_rd, input data_t rd_val);
    paddr_t pa;
    logic   fault;
    int     cycles;
    int     waited;
    @(posedge clk);
    // satp and the tables written one edge earlier are settled here
    ref_translate(va, we, pa, fault, cycles);
    cpu_cyc    <= 1'b1;
    cpu_stb    <= 1'b1;
    cpu_req    <= '{adr: va, we: we, sel: 4'hF, wdata: wdata};
    exp_adr    <= pa;
    exp_we     <= we;
    exp_err    <= fault;
    exp_cycles <= cycles;
    exp_rd     <= check_rd && !we;
    exp_dat    <= rd_val;
    waited = 0;
    do
    begin
      @(posedge clk);
      waited++;
    end
    while (!(cpu_ack || cpu_err) && waited < ACCESS_CYCLES);
    cpu_cyc <= 1'b0;
    cpu_stb <= 1'b0;
    if (!(cpu_ack || cpu_err))
    begin
      $display("%0t: no CPU response within %0d cycles for address %h",
               $time, ACCESS_CYCLES, va);
      timeouts++;
    end
  endtask

  task automatic flush_tlb();
    @(posedge clk);
    tlb_flush <= 1'b1;
    @(posedge clk);
    tlb_flush <= 1'b0;
    tlb_v   = '0;
    tlb_ptr = '0;
  endtask

  task automatic end_test(input int id);
    @(posedge clk);
    test_end <= 1'b1;
    test_id  <= id;
    @(posedge clk);
    test_end <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    while (rst)
      @(posedge clk);

    // Bare mode, VA equals PA
    access(32'h0000_0100, 1'b1, 32'hA5A5_0001, 1'b0, '0);
    access(32'h0000_0100, 1'b0, '0, 1'b1, 32'hA5A5_0001);
    end_test(1);

    // Root at ppn 1, level-0 table at ppn 2
    poke(34'h1004, make_pte(22'h2, 4'h1));
    poke(34'h1008, make_pte(22'h400, 4'h7));
    poke(34'h100C, make_pte(22'h401, 4'h7));
    poke(34'h1010, make_pte(22'h10, 4'h5));
    for (int k = 0; k < 6; k++)
      poke(34'h2000 + 34'(4 * k), make_pte(22'(3 + 4 * k), 4'h7));
    poke(34'h2018, make_pte(22'h1B, 4'h3));
    poke(34'h2020, make_pte(22'h23, 4'h7));
    @(posedge clk);
    satp <= '{mode: 1'b1, asid: 9'd0, ppn: 22'd1};

    // 4 KiB page walk
    access(page_va(0), 1'b1, 32'h2000_0000, 1'b0, '0);
    access(page_va(0), 1'b0, '0, 1'b1, 32'h2000_0000);
    end_test(2);

    // Superpage at vpn1 = 2
    access(32'h0080_3F00, 1'b1, 32'h3000_3F00, 1'b0, '0);
    access(32'h0080_3F00, 1'b0, '0, 1'b1, 32'h3000_3F00);
    end_test(3);

    // Five pages, then hits and evictions
    flush_tlb();
    for (int k = 0; k < 5; k++)
      access(page_va(k), 1'b1, 32'h4000_0000 + 32'(k), 1'b0, '0);
    access(page_va(0), 1'b0, '0, 1'b1, 32'h4000_0000);
    access(page_va(4), 1'b0, '0, 1'b1, 32'h4000_0004);
    access(page_va(2), 1'b0, '0, 1'b1, 32'h4000_0002);
    access(page_va(1), 1'b0, '0, 1'b1, 32'h4000_0001);
    end_test(4);

    // Faults
    access(32'h0140_0000, 1'b1, 32'hDEAD_0001, 1'b0, '0);
    access(page_va(7), 1'b1, 32'hDEAD_0002, 1'b0, '0);
    access(page_va(6), 1'b1, 32'hDEAD_0003, 1'b0, '0);
    access(page_va(6), 1'b0, '0, 1'b1, 32'h0000_0000);
    access(page_va(6), 1'b1, 32'hDEAD_0004, 1'b0, '0);
    access(32'h00C0_0000, 1'b0, '0, 1'b0, '0);
    access(32'h0100_0000, 1'b0, '0, 1'b0, '0);
    end_test(5);

    // Remap page 8 to ppn 0x27, same aliased word
    access(page_va(8), 1'b1, 32'h6000_0008, 1'b0, '0);
    poke(34'h2020, make_pte(22'h27, 4'h7));
    flush_tlb();
    access(page_va(8), 1'b0, '0, 1'b1, 32'h6000_0008);
    access(page_va(8), 1'b0, '0, 1'b1, 32'h6000_0008);
    end_test(6);

    repeat (4) @(posedge clk);
    $display("accesses %0d of %0d, mismatches %0d, timeouts %0d",
             checks, N_ACCESS, errors, timeouts);
    if (errors == 0 && timeouts == 0 && checks == N_ACCESS)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  // Watchdog
  initial
  begin
    repeat (N_ACCESS * ACCESS_CYCLES + SETUP_CYCLES) @(posedge clk);
    $display("watchdog expired before the test sequence ended");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/mmu_sva.sv
/* Wishbone protocol properties, bound into mmu_top
   Memory side properties assume a classic slave without pipelining */

`timescale 1ns/1ps
`default_nettype none

module mmu_sva (
  input logic              clk_i,
  input logic              rst_i,
  input logic              cpu_cyc_i,
  input logic              cpu_stb_i,
  input logic              cpu_ack_i,
  input logic              cpu_err_i,
  input logic              mem_cyc_i,
  input logic              mem_stb_i,
  input logic              mem_ack_i,
  input mmu_pkg::mem_req_t mem_req_i
);

  // One response kind per access
  ack_err_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !(cpu_ack_i && cpu_err_i)) else $error("cpu ack and err high together");

  stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_stb_i |-> mem_cyc_i) else $error("mem stb without cyc");

  // Master holds the request until ack
  req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (mem_stb_i && !mem_ack_i) |=> (mem_stb_i && $stable(mem_req_i)))
    else $error("mem request changed before ack");

  cpu_resp_req: assert property (@(posedge clk_i) disable iff (rst_i)
    (cpu_ack_i || cpu_err_i) |-> (cpu_cyc_i && cpu_stb_i))
    else $error("cpu response without request");

  mem_ack_req: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_ack_i |-> mem_cyc_i) else $error("mem ack without cycle");

endmodule

bind mmu_top mmu_sva sva0 (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .cpu_cyc_i (cpu_cyc_i),
  .cpu_stb_i (cpu_stb_i),
  .cpu_ack_i (cpu_ack_o),
  .cpu_err_i (cpu_err_o),
  .mem_cyc_i (mem_cyc_o),
  .mem_stb_i (mem_stb_o),
  .mem_ack_i (mem_ack_i),
  .mem_req_i (mem_req_o)
);

`default_nettype wire

// File: tb/mmu_checker.sv
/* Watches both Wishbone ports and compares each CPU response with the expectation
   Expectation inputs must be stable from the CPU strobe to the response */

`timescale 1ns/1ps
`default_nettype none

module mmu_checker (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              cpu_ack_i,
  input  logic              cpu_err_i,
  input  mmu_pkg::data_t    cpu_dat_i,
  input  logic              mem_cyc_i,
  input  logic              mem_stb_i,
  input  logic              mem_ack_i,
  input  mmu_pkg::mem_req_t mem_req_i,
  input  mmu_pkg::paddr_t   exp_adr_i,
  input  logic              exp_we_i,
  input  logic              exp_err_i,
  input  logic              exp_rd_i,
  input  int                exp_cycles_i,
  input  mmu_pkg::data_t    exp_dat_i,
  input  logic              test_end_i,
  input  int                test_id_i,
  output int                checks_o,
  output int                errors_o
);

  import mmu_pkg::*;

  // Per-access bus bookkeeping
  int     cycles;
  int     writes;
  paddr_t last_adr;
  logic   last_we;
  // Totals at the start of the running test
  int     checks_base;
  int     errors_base;

  task automatic report(input string name, input logic [63:0] exp, input logic [63:0] got);
    $display("MISMATCH %0t %s expected %h got %h", $time, name, exp, got);
    errors_o++;
  endtask

  task automatic compare_access();
    if (cpu_err_i != exp_err_i)
      report("cpu_err_o", 64'(exp_err_i), 64'(cpu_err_i));
    if (cycles != exp_cycles_i)
      report("memory cycles", 64'(exp_cycles_i), 64'(cycles));
    // Last bus cycle is the data access
    if (!exp_err_i && !cpu_err_i && cycles > 0)
    begin
      if (last_adr != exp_adr_i)
        report("mem_req_o.adr", 64'(exp_adr_i), 64'(last_adr));
      if (last_we != exp_we_i)
        report("mem_req_o.we", 64'(exp_we_i), 64'(last_we));
      if (exp_rd_i && cpu_dat_i != exp_dat_i)
        report("cpu_dat_o", 64'(exp_dat_i), 64'(cpu_dat_i));
    end
    if (cpu_err_i && writes != 0)
    begin
      $display("%0t: faulting access wrote memory %0d times", $time, writes);
      errors_o++;
    end
  endtask

  always @(posedge clk_i)
  begin
    if (rst_i)
    begin
      cycles      = 0;
      writes      = 0;
      last_adr    = '0;
      last_we     = 1'b0;
      checks_o    = 0;
      errors_o    = 0;
      checks_base = 0;
      errors_base = 0;
    end
    else
    begin
      // Count acknowledged memory cycles
      if (mem_cyc_i && mem_stb_i && mem_ack_i)
      begin
        cycles++;
        last_adr = mem_req_i.adr;
        last_we  = mem_req_i.we;
        if (mem_req_i.we)
          writes++;
      end
      if (cpu_ack_i || cpu_err_i)
      begin
        compare_access();
        cycles = 0;
        writes = 0;
        checks_o++;
      end
      if (test_end_i)
      begin
        $display("test %0d finished: %0d accesses, %0d errors", test_id_i,
                 checks_o - checks_base, errors_o - errors_base);
        checks_base = checks_o;
        errors_base = errors_o;
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_clkgen.sv
/* Free-running 4 ns clock and an active high reset held for RST_CYCLES edges */

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_o
);

  // 2 ns per half period
  initial
  begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial
  begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

`default_nettype wire

// File: rtl/mmu_top.sv
/* Sv32 MMU between a CPU Wishbone classic slave port and a memory master port
   satp_i must stay stable while a CPU access is in flight */

`timescale 1ns/1ps
`default_nettype none

module mmu_top (
  input  logic              clk_i,
  input  logic              rst_i,
  input  mmu_pkg::satp_t    satp_i,
  input  logic              tlb_flush_i,
  // CPU side
  input  logic              cpu_cyc_i,
  input  logic              cpu_stb_i,
  input  mmu_pkg::cpu_req_t cpu_req_i,
  output logic              cpu_ack_o,
  output logic              cpu_err_o,
  output mmu_pkg::data_t    cpu_dat_o,
  // Memory side
  input  mmu_pkg::data_t    mem_dat_i,
  input  logic              mem_ack_i,
  output logic              mem_cyc_o,
  output logic              mem_stb_o,
  output mmu_pkg::mem_req_t mem_req_o
);

  import mmu_pkg::*;

  logic     mport_req;
  logic     mport_done;
  data_t    mport_rdata;
  mem_req_t mport_mreq;

  riscv_mmu u_mmu (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .satp_i        (satp_i),
    .tlb_flush_i   (tlb_flush_i),
    .cpu_cyc_i     (cpu_cyc_i),
    .cpu_stb_i     (cpu_stb_i),
    .cpu_req_i     (cpu_req_i),
    .mport_done_i  (mport_done),
    .mport_rdata_i (mport_rdata),
    .cpu_ack_o     (cpu_ack_o),
    .cpu_err_o     (cpu_err_o),
    .cpu_dat_o     (cpu_dat_o),
    .mport_req_o   (mport_req),
    .mport_mreq_o  (mport_mreq)
  );

  mmu_mem_port u_mem_port (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_i     (mport_req),
    .mreq_i    (mport_mreq),
    .mem_dat_i (mem_dat_i),
    .mem_ack_i (mem_ack_i),
    .done_o    (mport_done),
    .rdata_o   (mport_rdata),
    .mem_cyc_o (mem_cyc_o),
    .mem_stb_o (mem_stb_o),
    .mem_req_o (mem_req_o)
  );

endmodule

`default_nettype wire

// File: rtl/riscv_mmu.sv
/* MMU control, bare or Sv32 by satp mode sampled at request start
   Page faults answer with a one-cycle err and make no data access */

`timescale 1ns/1ps
`default_nettype none

module riscv_mmu (
  input  logic              clk_i,
  input  logic              rst_i,
  input  mmu_pkg::satp_t    satp_i,
  input  logic              tlb_flush_i,
  input  logic              cpu_cyc_i,
  input  logic              cpu_stb_i,
  input  mmu_pkg::cpu_req_t cpu_req_i,
  input  logic              mport_done_i,
  input  mmu_pkg::data_t    mport_rdata_i,
  output logic              cpu_ack_o,
  output logic              cpu_err_o,
  output mmu_pkg::data_t    cpu_dat_o,
  output logic              mport_req_o,
  output mmu_pkg::mem_req_t mport_mreq_o
);

  import mmu_pkg::*;

  mmu_state_t state_q;
  mmu_state_t state_d;
  cpu_req_t   req_q;
  mem_req_t   mreq_q;
  vpn_t       vpn;

  // TLB and walker
  logic       tlb_hit;
  tlb_entry_t tlb_entry;
  logic       tlb_fill;
  logic       ptw_start;
  logic       ptw_req;
  paddr_t     ptw_adr;
  logic       ptw_done;
  logic       ptw_fault;
  tlb_entry_t ptw_entry;

  // Read needs R, write needs W
  function automatic logic perm_ok(tlb_entry_t e, logic we);
    return we ? e.w : e.r;
  endfunction

  // 4 KiB page or 4 MiB superpage
  function automatic paddr_t phys_adr(tlb_entry_t e, vaddr_t va);
    if (e.sp)
      return {e.ppn[PLEN-PAGE_BITS-1:VPN_LO_BITS], va[PAGE_BITS +: VPN_LO_BITS],
              va[PAGE_BITS-1:0]};
    return {e.ppn, va[PAGE_BITS-1:0]};
  endfunction

  assign vpn = req_q.adr[XLEN-1:PAGE_BITS];

  mmu_tlb u_tlb (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .flush_i      (tlb_flush_i),
    .vpn_i        (vpn),
    .fill_i       (tlb_fill),
    .fill_entry_i (ptw_entry),
    .hit_o        (tlb_hit),
    .entry_o      (tlb_entry)
  );

  mmu_ptw u_ptw (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .start_i     (ptw_start),
    .vpn_i       (vpn),
    .root_ppn_i  (satp_i.ppn),
    .mem_done_i  (mport_done_i),
    .mem_rdata_i (mport_rdata_i),
    .mem_req_o   (ptw_req),
    .mem_adr_o   (ptw_adr),
    .done_o      (ptw_done),
    .fault_o     (ptw_fault),
    .entry_o     (ptw_entry)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d      = state_q;
    mport_req_o  = 1'b0;
    mport_mreq_o = mreq_q;
    tlb_fill     = 1'b0;
    ptw_start    = 1'b0;
    case (state_q)
      ST_IDLE:
        if (cpu_cyc_i && cpu_stb_i)
        begin
          if (satp_i.mode == SATP_MODE_SV32)
            state_d = ST_LOOKUP;
          else
          begin
            // Bare, issue straight away
            mport_req_o  = 1'b1;
            mport_mreq_o = '{adr: paddr_t'(cpu_req_i.adr), we: cpu_req_i.we,
                             sel: cpu_req_i.sel, wdata: cpu_req_i.wdata};
            state_d      = ST_ACCESS;
          end
        end
      ST_LOOKUP:
        if (!tlb_hit)
        begin
          ptw_start = 1'b1;
          state_d   = ST_WALK;
        end
        else if (!perm_ok(tlb_entry, req_q.we))
          state_d = ST_RESP;
        else
        begin
          mport_req_o  = 1'b1;
          mport_mreq_o = '{adr: phys_adr(tlb_entry, req_q.adr), we: req_q.we,
                           sel: req_q.sel, wdata: req_q.wdata};
          state_d      = ST_ACCESS;
        end
      ST_WALK:
      begin
        // Walker owns the port, word reads only
        mport_req_o  = ptw_req;
        mport_mreq_o = '{adr: ptw_adr, we: 1'b0, sel: '1, wdata: '0};
        if (ptw_done)
        begin
          tlb_fill = !ptw_fault;
          // Retry the lookup, it hits on the new entry
          if (ptw_fault || !perm_ok(ptw_entry, req_q.we))
            state_d = ST_RESP;
          else
            state_d = ST_LOOKUP;
        end
      end
      ST_ACCESS:
      begin
        mport_req_o = 1'b1;
        if (mport_done_i)
          state_d = ST_IDLE;
      end
      default:
        state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  // Latched CPU request and held data request
  always_ff @(posedge clk_i)
  begin
    if (state_q == ST_IDLE)
      req_q <= cpu_req_i;
    if (state_q != ST_ACCESS)
      mreq_q <= mport_mreq_o;
  end

  // CPU response
  assign cpu_ack_o = (state_q == ST_ACCESS) && mport_done_i;
  assign cpu_err_o = (state_q == ST_RESP);
  assign cpu_dat_o = mport_rdata_i;

endmodule

`default_nettype wire

// File: rtl/mmu_mem_port.sv
/* Wishbone classic master, one access in flight
   req_i is ignored until done_o has been returned */

`timescale 1ns/1ps
`default_nettype none

module mmu_mem_port (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              req_i,
  input  mmu_pkg::mem_req_t mreq_i,
  input  mmu_pkg::data_t    mem_dat_i,
  input  logic              mem_ack_i,
  output logic              done_o,
  output mmu_pkg::data_t    rdata_o,
  output logic              mem_cyc_o,
  output logic              mem_stb_o,
  output mmu_pkg::mem_req_t mem_req_o
);

  import mmu_pkg::*;

  // Busy spans the bus cycle and the done cycle
  logic     busy_q;
  logic     cyc_q;
  logic     done_q;
  mem_req_t req_q;
  data_t    rdata_q;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      busy_q <= 1'b0;
      cyc_q  <= 1'b0;
      done_q <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      if (!busy_q && req_i)
      begin
        busy_q <= 1'b1;
        cyc_q  <= 1'b1;
      end
      // Drop the cycle on ack
      if (cyc_q && mem_ack_i)
      begin
        cyc_q  <= 1'b0;
        done_q <= 1'b1;
      end
      if (done_q)
        busy_q <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk_i)
  begin
    if (!busy_q && req_i)
      req_q <= mreq_i;
    if (cyc_q && mem_ack_i)
      rdata_q <= mem_dat_i;
  end

  assign mem_cyc_o = cyc_q;
  assign mem_stb_o = cyc_q;
  assign mem_req_o = req_q;
  assign done_o    = done_q;
  assign rdata_o   = rdata_q;

endmodule

`default_nettype wire

// File: rtl/mmu_ptw.sv
/* Sv32 two-level walker, one PTE read per level over a request/done pair
   A/D bits and U/X permissions are not checked, R/W go into the entry */

`timescale 1ns/1ps
`default_nettype none

module mmu_ptw (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                start_i,
  input  mmu_pkg::vpn_t       vpn_i,
  input  mmu_pkg::ppn_t       root_ppn_i,
  input  logic                mem_done_i,
  input  mmu_pkg::pte_t       mem_rdata_i,
  output logic                mem_req_o,
  output mmu_pkg::paddr_t     mem_adr_o,
  output logic                done_o,
  output logic                fault_o,
  output mmu_pkg::tlb_entry_t entry_o
);

  import mmu_pkg::*;

  ptw_state_t state_q;
  vpn_t       vpn_q;
  paddr_t     adr_q;
  tlb_entry_t entry_q;
  logic       fault_q;

  // PTE decode
  ppn_t pte_ppn;
  logic pte_bad;
  logic pte_leaf;
  logic sp_misaligned;

  assign pte_ppn       = mem_rdata_i[XLEN-1:PTE_PPN_LSB];
  // Invalid or W without R
  assign pte_bad       = !mem_rdata_i[PTE_V] || (mem_rdata_i[PTE_W] && !mem_rdata_i[PTE_R]);
  assign pte_leaf      = mem_rdata_i[PTE_R] || mem_rdata_i[PTE_X];
  // Superpage leaf must have ppn[9:0] clear
  assign sp_misaligned = |pte_ppn[VPN_LO_BITS-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Walk FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      state_q <= PTW_IDLE;
    else
    begin
      case (state_q)
        PTW_IDLE:
          if (start_i)
            state_q <= PTW_L1_REQ;
        PTW_L1_REQ:
          state_q <= PTW_L1_WAIT;
        PTW_L1_WAIT:
          if (mem_done_i)
            state_q <= (pte_bad || pte_leaf) ? PTW_DONE : PTW_L0_REQ;
        PTW_L0_REQ:
          state_q <= PTW_L0_WAIT;
        PTW_L0_WAIT:
          if (mem_done_i)
            state_q <= PTW_DONE;
        default:
          state_q <= PTW_IDLE;
      endcase
    end
  end

  // Table address and result
  always_ff @(posedge clk_i)
  begin
    if (state_q == PTW_IDLE && start_i)
    begin
      vpn_q <= vpn_i;
      // Root times 4096 plus vpn[19:10] times 4
      adr_q <= {root_ppn_i, vpn_i[VPN_LO_BITS +: VPN_LO_BITS], 2'b00};
    end
    if (state_q == PTW_L1_WAIT && mem_done_i)
    begin
      adr_q   <= {pte_ppn, vpn_q[VPN_LO_BITS-1:0], 2'b00};
      fault_q <= pte_bad || (pte_leaf && sp_misaligned);
      entry_q <= '{vpn: vpn_q, ppn: pte_ppn, sp: 1'b1,
                   r: mem_rdata_i[PTE_R], w: mem_rdata_i[PTE_W]};
    end
    if (state_q == PTW_L0_WAIT && mem_done_i)
    begin
      // Pointer at level 0 is a fault too
      fault_q <= pte_bad || !pte_leaf;
      entry_q <= '{vpn: vpn_q, ppn: pte_ppn, sp: 1'b0,
                   r: mem_rdata_i[PTE_R], w: mem_rdata_i[PTE_W]};
    end
  end

  // Request held from REQ through WAIT
  assign mem_req_o = (state_q == PTW_L1_REQ) || (state_q == PTW_L1_WAIT) ||
                     (state_q == PTW_L0_REQ) || (state_q == PTW_L0_WAIT);
  assign mem_adr_o = adr_q;
  assign done_o    = (state_q == PTW_DONE);
  assign fault_o   = fault_q;
  assign entry_o   = entry_q;

endmodule

`default_nettype wire

// File: rtl/mmu_tlb.sv
/* Fully associative TLB, lookup is combinational on vpn_i
   Fill writes the round-robin victim, flush wins over a fill in the same cycle */

`timescale 1ns/1ps
`default_nettype none

module mmu_tlb (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                flush_i,
  input  mmu_pkg::vpn_t       vpn_i,
  input  logic                fill_i,
  input  mmu_pkg::tlb_entry_t fill_entry_i,
  output logic                hit_o,
  output mmu_pkg::tlb_entry_t entry_o
);

  import mmu_pkg::*;

  tlb_entry_t              entries_q [TLB_ENTRIES];
  logic [TLB_ENTRIES-1:0]  valid_q;
  logic [TLB_ENTRIES-1:0]  match;
  logic [TLB_PTR_BITS-1:0] victim_q;

  ////////////////////////////////////////////////////////////////////////////
  // Lookup
  ////////////////////////////////////////////////////////////////////////////

  // Superpage ignores the level-0 index
  always_comb
  begin
    for (int i = 0; i < TLB_ENTRIES; i++)
    begin
      match[i] = valid_q[i] &&
                 (vpn_i[VPN_LO_BITS +: VPN_LO_BITS] ==
                  entries_q[i].vpn[VPN_LO_BITS +: VPN_LO_BITS]) &&
                 (entries_q[i].sp ||
                  (vpn_i[VPN_LO_BITS-1:0] == entries_q[i].vpn[VPN_LO_BITS-1:0]));
    end
  end

  // At most one entry matches, fills only follow a miss
  always_comb
  begin
    entry_o = '0;
    for (int i = 0; i < TLB_ENTRIES; i++)
    begin
      if (match[i])
        entry_o = entries_q[i];
    end
  end

  assign hit_o = |match;

  ////////////////////////////////////////////////////////////////////////////
  // Fill and flush
  ////////////////////////////////////////////////////////////////////////////

  // Flush also restarts the victim pointer
  always_ff @(posedge clk_i)
  begin
    if (rst_i || flush_i)
    begin
      valid_q  <= '0;
      victim_q <= '0;
    end
    else if (fill_i)
    begin
      valid_q[victim_q] <= 1'b1;
      victim_q          <= victim_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (fill_i)
      entries_q[victim_q] <= fill_entry_i;
  end

endmodule

`default_nettype wire

// File: rtl/mmu_pkg.sv
/* Shared widths, PTE fields and types of the Sv32 MMU
   ASID bits of satp are carried but never compared */

`default_nettype none

package mmu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int XLEN         = 32;
  localparam int PLEN         = 34;
  localparam int PAGE_BITS    = 12;
  localparam int VPN_LO_BITS  = 10;   // Bits per table index
  localparam int TLB_ENTRIES  = 4;
  localparam int TLB_PTR_BITS = $clog2(TLB_ENTRIES);

  // PTE flag positions
  localparam int PTE_V        = 0;
  localparam int PTE_R        = 1;
  localparam int PTE_W        = 2;
  localparam int PTE_X        = 3;
  localparam int PTE_PPN_LSB  = 10;

  localparam logic SATP_MODE_SV32 = 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [XLEN-1:0]           vaddr_t;
  typedef logic [PLEN-1:0]           paddr_t;
  typedef logic [XLEN-PAGE_BITS-1:0] vpn_t;
  typedef logic [PLEN-PAGE_BITS-1:0] ppn_t;
  typedef logic [XLEN-1:0]           pte_t;
  typedef logic [XLEN-1:0]           data_t;
  typedef logic [XLEN/8-1:0]         sel_t;

  // Same bit layout as the satp CSR
  typedef struct packed {
    logic       mode;
    logic [8:0] asid;
    ppn_t       ppn;
  } satp_t;

  typedef struct packed {
    vaddr_t adr;
    logic   we;
    sel_t   sel;
    data_t  wdata;
  } cpu_req_t;

  typedef struct packed {
    paddr_t adr;
    logic   we;
    sel_t   sel;
    data_t  wdata;
  } mem_req_t;

  // sp marks a 4 MiB superpage
  typedef struct packed {
    vpn_t vpn;
    ppn_t ppn;
    logic sp;
    logic r;
    logic w;
  } tlb_entry_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_WALK,
    ST_ACCESS,
    ST_RESP
  } mmu_state_t;

  typedef enum logic [2:0] {
    PTW_IDLE,
    PTW_L1_REQ,
    PTW_L1_WAIT,
    PTW_L0_REQ,
    PTW_L0_WAIT,
    PTW_DONE
  } ptw_state_t;

endpackage

`default_nettype wire
